// ==== logic/pw_fe_capture.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pw_sniffer_config.svh"

module pw_fe_capture (
   input  wire                                 fe_clk,
   input  wire                                 arst_n_i,
   input  wire pw_sniffer_pkg::pw_utmi_rx_t    utmi_rx_i,
   input  wire                                 capture_start_i,
   input  wire pw_sniffer_pkg::pw_len_t        cap_len_i,
   input  wire                                 ts_disable_i,
   input  wire                                 credit_i,
   output pw_sniffer_pkg::pw_capture_rec_t     rec_o,
   output logic                                rec_valid_o,
   output logic                                capturing_o,
   output logic                                overflow_o
);
   import pw_sniffer_pkg::*;

   localparam int AW     = $clog2(`PW_FIFO_DEPTH);
   localparam int PTR_W  = AW + 1;
   localparam int CRED_W = $clog2(`PW_CREDITS + 1);

   pw_cap_state_e     state_q;
   pw_ts_t            ts_q;
   pw_len_t           cnt_q;
   pw_capture_rec_t   fifo_mem [`PW_FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CRED_W-1:0] credits_q;
   logic              take;
   logic              fifo_full;
   logic              fifo_empty;
   logic              push;
   logic              send;
   pw_capture_rec_t   new_rec;

   assign capturing_o = (state_q == CAP_CAPTURING);
   assign take        = capturing_o && utmi_rx_i.rxvalid && utmi_rx_i.rxactive;
   assign fifo_empty  = (wr_ptr_q == rd_ptr_q);
   assign fifo_full   = (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]) &&
                        (wr_ptr_q[AW] != rd_ptr_q[AW]);
   assign push        = take && !fifo_full;
   assign send        = !fifo_empty && (credits_q != '0);

   assign new_rec = '{timestamp: ts_disable_i ? pw_ts_t'(0) : ts_q,
                      data:      utmi_rx_i.data,
                      rxerror:   utmi_rx_i.rxerror};

   ////////////////////////////////////////
   // capture FSM and timestamp
   ////////////////////////////////////////
   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= CAP_IDLE;
         ts_q       <= '0;
         cnt_q      <= '0;
         overflow_o <= 1'b0;
      end else begin
         overflow_o <= take && fifo_full;   // dropped byte
         if (capture_start_i) begin
            state_q <= (cap_len_i == '0) ? CAP_IDLE : CAP_CAPTURING;
            ts_q    <= pw_ts_t'(1);   // first cycle after the start pulse
            cnt_q   <= '0;
         end else if (capturing_o) begin
            ts_q <= ts_q + pw_ts_t'(1);
            if (take) begin   // dropped bytes still count toward the length
               cnt_q <= cnt_q + pw_len_t'(1);
               if (cnt_q == cap_len_i - pw_len_t'(1)) begin
                  state_q <= CAP_IDLE;
               end
            end
         end
      end
   end

   ////////////////////////////////////////
   // record FIFO and credit sender
   ////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (push) begin
         fifo_mem[wr_ptr_q[AW-1:0]] <= new_rec;
      end
      if (send) begin
         rec_o <= fifo_mem[rd_ptr_q[AW-1:0]];
      end
   end

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         credits_q   <= CRED_W'(`PW_CREDITS);
         rec_valid_o <= 1'b0;
      end else begin
         rec_valid_o <= send;
         if (push) begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(1);
         end
         if (send) begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(1);
         end
         case ({send, credit_i})
            2'b10:   credits_q <= credits_q - CRED_W'(1);
            2'b01:   credits_q <= credits_q + CRED_W'(1);
            default: ;   // none, or one spent and one back
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/pw_pattern_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pw_sniffer_config.svh"

module pw_pattern_matcher (
   input  wire                                fe_clk,
   input  wire                                arst_n_i,
   input  wire pw_sniffer_pkg::pw_utmi_rx_t   utmi_rx_i,
   input  wire                                arm_i,
   input  wire pw_sniffer_pkg::pw_pattern_t   pattern_i,
   input  wire pw_sniffer_pkg::pw_pattern_t   mask_i,
   output logic                               match_o
);
   import pw_sniffer_pkg::*;

   localparam int CNT_W = $clog2(`PW_PATTERN_BYTES + 1);

   pw_pattern_t      hist_q;       // newest byte at the top index
   logic [CNT_W-1:0] seen_q;       // bytes of this packet, saturating
   logic             new_byte_q;
   logic             done_q;
   logic             full;
   logic             hit;
   logic             match_d;

   assign full = (seen_q == CNT_W'(`PW_PATTERN_BYTES));

   // only bits with a set mask bit take part
   assign hit = ((hist_q ^ pattern_i) & mask_i) == '0;

   // compare once per new byte, fire once per arm
   assign match_d = arm_i && !done_q && new_byte_q && full && hit;

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hist_q     <= '0;
         seen_q     <= '0;
         new_byte_q <= 1'b0;
         done_q     <= 1'b0;
         match_o    <= 1'b0;
      end else begin
         new_byte_q <= utmi_rx_i.rxvalid && utmi_rx_i.rxactive;
         match_o    <= match_d;

         if (!utmi_rx_i.rxactive) begin   // packet over, start afresh
            hist_q <= '0;
            seen_q <= '0;
         end else if (utmi_rx_i.rxvalid) begin
            hist_q <= {utmi_rx_i.data, hist_q[`PW_PATTERN_BYTES-1:1]};
            if (!full) begin
               seen_q <= seen_q + CNT_W'(1);
            end
         end

         if (!arm_i) begin
            done_q <= 1'b0;
         end else if (match_d) begin
            done_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/pw_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pw_sniffer_config.svh"

module pw_reg_file (
   input  wire                                 fe_clk,
   input  wire                                 arst_n_i,
   input  wire pw_sniffer_pkg::pw_reg_addr_t   reg_addr_i,
   input  wire pw_sniffer_pkg::pw_byte_t       reg_wdata_i,
   input  wire                                 reg_write_i,
   input  wire                                 reg_read_i,
   input  wire                                 fired_i,
   input  wire                                 capturing_i,
   input  wire                                 overflow_i,
   output pw_sniffer_pkg::pw_byte_t            reg_rdata_o,
   output logic                                arm_o,
   output pw_sniffer_pkg::pw_pattern_t         pattern_o,
   output pw_sniffer_pkg::pw_pattern_t         mask_o,
   output pw_sniffer_pkg::pw_trig_cfg_t        trig_cfg_o,
   output pw_sniffer_pkg::pw_len_t             cap_len_o,
   output logic                                ts_disable_o,
   output logic [1:0]                          fe_xcvrsel_o,
   output logic                                fe_termsel_o
);
   import pw_sniffer_pkg::*;

   logic       trig_en_q;
   pw_delay_t  delay_q;
   pw_width_t  width_q;
   pw_speed_e  speed_q;
   logic       ovf_q;      // sticky, cleared by a control write
   logic       fired_q;
   logic [1:0] byte_idx;
   pw_byte_t   rd_mux;

   // pattern and mask banks both start one past a multiple of four
   assign byte_idx   = reg_addr_i[1:0] - 2'd1;
   assign trig_cfg_o = '{delay: delay_q, width: width_q, enable: trig_en_q};

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////
   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         arm_o        <= 1'b0;
         trig_en_q    <= 1'b0;
         ts_disable_o <= 1'b0;
         pattern_o    <= '0;
         mask_o       <= '0;
         delay_q      <= '0;
         width_q      <= '0;
         cap_len_o    <= '0;
         speed_q      <= SPEED_FS;
         ovf_q        <= 1'b0;
         fired_q      <= 1'b0;
      end else begin
         if (reg_write_i) begin
            case (reg_addr_i) inside
               `PW_REG_CTRL: begin
                  arm_o        <= reg_wdata_i[0];
                  trig_en_q    <= reg_wdata_i[1];
                  ts_disable_o <= reg_wdata_i[2];
                  ovf_q        <= 1'b0;
                  fired_q      <= 1'b0;
               end
               [`PW_REG_PATTERN:`PW_REG_MASK - 4'd1]: pattern_o[byte_idx] <= reg_wdata_i;
               [`PW_REG_MASK:`PW_REG_DELAY - 4'd1]:   mask_o[byte_idx] <= reg_wdata_i;
               `PW_REG_DELAY:        delay_q[7:0] <= reg_wdata_i;
               `PW_REG_DELAY + 4'd1: delay_q[`PW_DELAY_WIDTH-1:8] <= reg_wdata_i[`PW_DELAY_WIDTH-9:0];
               `PW_REG_WIDTH:        width_q[7:0] <= reg_wdata_i;
               `PW_REG_WIDTH + 4'd1: width_q[`PW_WIDTH_WIDTH-1:8] <= reg_wdata_i[`PW_WIDTH_WIDTH-9:0];
               `PW_REG_LEN:          cap_len_o <= pw_len_t'(reg_wdata_i);
               `PW_REG_SPEED:        speed_q <= pw_speed_e'(reg_wdata_i[1:0]);
               default: ;
            endcase
         end
         if (fired_i) begin   // one trigger per arm
            arm_o   <= 1'b0;
            fired_q <= 1'b1;
         end
         if (overflow_i) begin
            ovf_q <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////
   always_comb begin
      rd_mux = '0;
      case (reg_addr_i) inside
         `PW_REG_CTRL:                          rd_mux = {5'd0, ts_disable_o, trig_en_q, arm_o};
         [`PW_REG_PATTERN:`PW_REG_MASK - 4'd1]: rd_mux = pattern_o[byte_idx];
         [`PW_REG_MASK:`PW_REG_DELAY - 4'd1]:   rd_mux = mask_o[byte_idx];
         `PW_REG_DELAY:                         rd_mux = delay_q[7:0];
         `PW_REG_DELAY + 4'd1:                  rd_mux = pw_byte_t'(delay_q >> 8);
         `PW_REG_WIDTH:                         rd_mux = width_q[7:0];
         `PW_REG_WIDTH + 4'd1:                  rd_mux = pw_byte_t'(width_q >> 8);
         `PW_REG_LEN:                           rd_mux = pw_byte_t'(cap_len_o);
         `PW_REG_SPEED:                         rd_mux = {6'd0, speed_q};
         `PW_REG_STATUS:                        rd_mux = {5'd0, fired_q, ovf_q, capturing_i};
         default: ;
      endcase
   end

   always_ff @(posedge fe_clk) begin
      if (reg_read_i) begin
         reg_rdata_o <= rd_mux;
      end
   end

   // transceiver select and termination per bus speed
   always_comb begin
      case (speed_q)
         SPEED_LS: begin
            fe_xcvrsel_o = 2'b10;
            fe_termsel_o = 1'b1;
         end
         SPEED_HS: begin
            fe_xcvrsel_o = 2'b00;
            fe_termsel_o = 1'b0;
         end
         default: begin   // FS, and AUTO until detection exists
            fe_xcvrsel_o = 2'b01;
            fe_termsel_o = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/pw_sniffer_config.svh ====
`ifndef PW_SNIFFER_CONFIG_SVH
`define PW_SNIFFER_CONFIG_SVH

// matcher and trigger sizing
`define PW_PATTERN_BYTES 4
`define PW_TS_WIDTH      16
`define PW_DELAY_WIDTH   16
`define PW_WIDTH_WIDTH   12
`define PW_LEN_WIDTH     8

// record path
`define PW_CREDITS       4
`define PW_FIFO_DEPTH    8

// register map
`define PW_REG_CTRL      4'd0   // arm, trigger enable, timestamps disable
`define PW_REG_PATTERN   4'd1   // 4 bytes, first byte on the wire first
`define PW_REG_MASK      4'd5   // 4 bytes
`define PW_REG_DELAY     4'd9   // low then high byte
`define PW_REG_WIDTH     4'd11  // low then high byte
`define PW_REG_LEN       4'd13
`define PW_REG_SPEED     4'd14
`define PW_REG_STATUS    4'd15  // capturing, overflow, fired

`endif

// ==== logic/pw_sniffer_pkg.sv ====
`default_nettype none
`include "pw_sniffer_config.svh"

package pw_sniffer_pkg;

   typedef logic [7:0]                 pw_byte_t;
   typedef logic [`PW_TS_WIDTH-1:0]    pw_ts_t;
   typedef logic [`PW_DELAY_WIDTH-1:0] pw_delay_t;
   typedef logic [`PW_WIDTH_WIDTH-1:0] pw_width_t;
   typedef logic [`PW_LEN_WIDTH-1:0]   pw_len_t;
   typedef logic [3:0]                 pw_reg_addr_t;

   // index 0 is the oldest byte of the window
   typedef pw_byte_t [`PW_PATTERN_BYTES-1:0] pw_pattern_t;

   // receive side of the UTMI front end
   typedef struct packed {
      pw_byte_t data;
      logic     rxvalid;
      logic     rxactive;
      logic     rxerror;
   } pw_utmi_rx_t;

   typedef struct packed {
      pw_ts_t   timestamp;
      pw_byte_t data;
      logic     rxerror;
   } pw_capture_rec_t;

   typedef struct packed {
      pw_delay_t delay;
      pw_width_t width;
      logic      enable;
   } pw_trig_cfg_t;

   typedef enum logic [1:0] {
      SPEED_LS   = 2'd0,
      SPEED_FS   = 2'd1,
      SPEED_HS   = 2'd2,
      SPEED_AUTO = 2'd3
   } pw_speed_e;

   typedef enum logic {CAP_IDLE, CAP_CAPTURING} pw_cap_state_e;

   typedef enum logic [1:0] {TRIG_IDLE, TRIG_DELAY, TRIG_PULSE} pw_trig_state_e;

endpackage

`default_nettype wire

// ==== logic/pw_sniffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_sniffer_top (
   input  wire                                 fe_clk,
   input  wire                                 arst_n_i,
   // register port
   input  wire pw_sniffer_pkg::pw_reg_addr_t   reg_addr_i,
   input  wire pw_sniffer_pkg::pw_byte_t       reg_wdata_i,
   input  wire                                 reg_write_i,
   input  wire                                 reg_read_i,
   output pw_sniffer_pkg::pw_byte_t            reg_rdata_o,
   // front end
   input  wire pw_sniffer_pkg::pw_utmi_rx_t    utmi_rx_i,
   output logic [1:0]                          fe_xcvrsel_o,
   output logic                                fe_termsel_o,
   // trigger and leds
   output logic                                trig_o,
   output logic                                led_arm_o,
   output logic                                led_cap_o,
   // record stream
   output pw_sniffer_pkg::pw_capture_rec_t     rec_o,
   output logic                                rec_valid_o,
   input  wire                                 credit_i
);
   import pw_sniffer_pkg::*;

   logic         arm;
   pw_pattern_t  pattern;
   pw_pattern_t  mask;
   pw_trig_cfg_t trig_cfg;
   pw_len_t      cap_len;
   logic         ts_disable;
   logic         match;
   logic         capture_start;
   logic         fired;
   logic         capturing;
   logic         overflow;

   assign led_arm_o = arm;
   assign led_cap_o = capturing;

   pw_reg_file reg_file_inst (
      .fe_clk       (fe_clk),
      .arst_n_i     (arst_n_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_write_i  (reg_write_i),
      .reg_read_i   (reg_read_i),
      .fired_i      (fired),
      .capturing_i  (capturing),
      .overflow_i   (overflow),
      .reg_rdata_o  (reg_rdata_o),
      .arm_o        (arm),
      .pattern_o    (pattern),
      .mask_o       (mask),
      .trig_cfg_o   (trig_cfg),
      .cap_len_o    (cap_len),
      .ts_disable_o (ts_disable),
      .fe_xcvrsel_o (fe_xcvrsel_o),
      .fe_termsel_o (fe_termsel_o)
   );

   pw_pattern_matcher pattern_matcher_inst (
      .fe_clk    (fe_clk),
      .arst_n_i  (arst_n_i),
      .utmi_rx_i (utmi_rx_i),
      .arm_i     (arm),
      .pattern_i (pattern),
      .mask_i    (mask),
      .match_o   (match)
   );

   pw_trigger trigger_inst (
      .fe_clk          (fe_clk),
      .arst_n_i        (arst_n_i),
      .match_i         (match),
      .trig_cfg_i      (trig_cfg),
      .trig_o          (trig_o),
      .capture_start_o (capture_start),
      .fired_o         (fired)
   );

   pw_fe_capture fe_capture_inst (
      .fe_clk          (fe_clk),
      .arst_n_i        (arst_n_i),
      .utmi_rx_i       (utmi_rx_i),
      .capture_start_i (capture_start),
      .cap_len_i       (cap_len),
      .ts_disable_i    (ts_disable),
      .credit_i        (credit_i),
      .rec_o           (rec_o),
      .rec_valid_o     (rec_valid_o),
      .capturing_o     (capturing),
      .overflow_o      (overflow)
   );

endmodule

`default_nettype wire

// ==== logic/pw_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_trigger (
   input  wire                                fe_clk,
   input  wire                                arst_n_i,
   input  wire                                match_i,
   input  wire pw_sniffer_pkg::pw_trig_cfg_t  trig_cfg_i,
   output logic                               trig_o,
   output logic                               capture_start_o,
   output logic                               fired_o
);
   import pw_sniffer_pkg::*;

   pw_trig_state_e state_q;
   pw_delay_t      delay_cnt_q;
   pw_width_t      width_cnt_q;
   pw_width_t      width_load;
   logic           launch;

   // zero delay goes straight from the match to the pulse
   assign launch = (state_q == TRIG_IDLE && match_i && trig_cfg_i.enable &&
                    trig_cfg_i.delay == '0) ||
                   (state_q == TRIG_DELAY && delay_cnt_q == '0);

   assign width_load = (trig_cfg_i.width == '0) ? '0 : trig_cfg_i.width - pw_width_t'(1);

   assign fired_o = capture_start_o;   // same edge as trig_o rising

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q         <= TRIG_IDLE;
         delay_cnt_q     <= '0;
         width_cnt_q     <= '0;
         trig_o          <= 1'b0;
         capture_start_o <= 1'b0;
      end else begin
         capture_start_o <= launch;
         if (launch) begin
            state_q     <= TRIG_PULSE;
            trig_o      <= 1'b1;
            width_cnt_q <= width_load;
         end else begin
            case (state_q)
               TRIG_IDLE: begin
                  if (match_i && trig_cfg_i.enable) begin   // nonzero delay here
                     state_q     <= TRIG_DELAY;
                     delay_cnt_q <= trig_cfg_i.delay - pw_delay_t'(1);
                  end
               end
               TRIG_DELAY: delay_cnt_q <= delay_cnt_q - pw_delay_t'(1);
               TRIG_PULSE: begin
                  if (width_cnt_q == '0) begin
                     trig_o  <= 1'b0;
                     state_q <= TRIG_IDLE;
                  end else begin
                     width_cnt_q <= width_cnt_q - pw_width_t'(1);
                  end
               end
               default: state_q <= TRIG_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== pw_sniffer_top.f ====
+incdir+logic
logic/pw_sniffer_pkg.sv
logic/pw_reg_file.sv
logic/pw_pattern_matcher.sv
logic/pw_trigger.sv
logic/pw_fe_capture.sv
logic/pw_sniffer_top.sv
tb/pw_sniffer_props.sv
tb/tb_pw_sniffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sniffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f pw_sniffer_top.f --top-module tb_pw_sniffer -Mdir "$OBJ" -o sim_pw_sniffer
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"$OBJ/sim_pw_sniffer" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi
exit 0

// ==== tb/pw_sniffer_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pw_sniffer_config.svh"

module pw_sniffer_props (
   input wire                                fe_clk,
   input wire                                arst_n_i,
   input wire pw_sniffer_pkg::pw_utmi_rx_t   utmi_rx_i,
   input wire pw_sniffer_pkg::pw_trig_cfg_t  trig_cfg_i,
   input wire pw_sniffer_pkg::pw_len_t       cap_len_i,
   input wire                                trig_o,
   input wire                                rec_valid_o,
   input wire                                credit_i,
   input wire                                led_arm_o,
   input wire                                led_cap_o
);
   import pw_sniffer_pkg::*;

   int        pkt_bytes;     // valid bytes of this packet, saturating
   int        since_byte;    // cycles since the last pattern byte at a packet head
   int        high_cnt;
   int        outstanding;   // records out, credits not yet back
   int        fail_cnt = 0;
   pw_width_t eff_width;
   logic      head_last;

   assign eff_width = (trig_cfg_i.width == '0) ? pw_width_t'(1) : trig_cfg_i.width;

   // packets open with the pattern, so its last byte completes the match
   assign head_last = utmi_rx_i.rxactive && utmi_rx_i.rxvalid &&
                      (pkt_bytes == `PW_PATTERN_BYTES - 1);

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pkt_bytes   <= 0;
         since_byte  <= 0;
         high_cnt    <= 0;
         outstanding <= 0;
      end else begin
         if (!utmi_rx_i.rxactive) begin
            pkt_bytes <= 0;
         end else if (utmi_rx_i.rxvalid && pkt_bytes < `PW_PATTERN_BYTES) begin
            pkt_bytes <= pkt_bytes + 1;
         end
         since_byte  <= head_last ? 0 : since_byte + 1;
         high_cnt    <= trig_o ? high_cnt + 1 : 0;
         outstanding <= outstanding + int'(rec_valid_o) - int'(credit_i);
      end
   end

   a_reset_quiet: assert property (@(posedge fe_clk)
      !arst_n_i |-> !trig_o && !rec_valid_o && !led_arm_o && !led_cap_o)
      else begin fail_cnt++; $error("outputs active during reset"); end

   a_trig_delay: assert property (@(posedge fe_clk) disable iff (!arst_n_i)
      $rose(trig_o) |-> since_byte == int'(trig_cfg_i.delay) + 2)
      else begin fail_cnt++; $error("trigger rose at the wrong cycle"); end

   a_trig_width: assert property (@(posedge fe_clk) disable iff (!arst_n_i)
      $fell(trig_o) |-> high_cnt == int'(eff_width))
      else begin fail_cnt++; $error("trigger pulse has the wrong width"); end

   a_capture_after_trig: assert property (@(posedge fe_clk) disable iff (!arst_n_i)
      $rose(trig_o) && cap_len_i != '0 |=> led_cap_o)
      else begin fail_cnt++; $error("capture did not start after the trigger"); end

   a_credit_limit: assert property (@(posedge fe_clk) disable iff (!arst_n_i)
      outstanding <= `PW_CREDITS)
      else begin fail_cnt++; $error("more records outstanding than credits"); end

endmodule

bind pw_sniffer_top pw_sniffer_props props_inst (
   .fe_clk          (fe_clk),
   .arst_n_i        (arst_n_i),
   .utmi_rx_i       (utmi_rx_i),
   .trig_cfg_i      (trig_cfg),
   .cap_len_i       (cap_len),
   .trig_o          (trig_o),
   .rec_valid_o     (rec_valid_o),
   .credit_i        (credit_i),
   .led_arm_o       (led_arm_o),
   .led_cap_o       (led_cap_o)
);

`default_nettype wire

// ==== tb/tb_pw_sniffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pw_sniffer_config.svh"

module tb_pw_sniffer;
   import pw_sniffer_pkg::*;

   localparam int TIMEOUT_CYCLES = 4000;

   logic            fe_clk = 1'b0;
   logic            arst_n_i;
   pw_reg_addr_t    reg_addr_i;
   pw_byte_t        reg_wdata_i;
   logic            reg_write_i;
   logic            reg_read_i;
   pw_byte_t        reg_rdata_o;
   pw_utmi_rx_t     utmi_rx_i;
   logic [1:0]      fe_xcvrsel_o;
   logic            fe_termsel_o;
   logic            trig_o;
   logic            led_arm_o;
   logic            led_cap_o;
   pw_capture_rec_t rec_o;
   logic            rec_valid_o;
   logic            credit_i = 1'b0;

   pw_capture_rec_t exp_q[$];      // expected records, oldest first
   pw_capture_rec_t exp_rec;
   pw_capture_rec_t cap_rec;
   integer          seed = 79;
   int              err_cnt = 0;
   int              cycles = 0;
   int              rec_cnt = 0;
   int              owed = 0;      // credits still to hand back
   int              trig_rises = 0;
   int              cap_len = 0;
   int              keep_limit = 255;
   int              ts_cnt = 0;
   int              cap_left = 0;
   int              cap_taken = 0;
   logic            trig_q = 1'b0;
   logic            auto_credit = 1'b1;
   logic            ts_dis = 1'b0;

   always #5 fe_clk = ~fe_clk;

   pw_sniffer_top pw_sniffer_top_inst (
      .fe_clk       (fe_clk),
      .arst_n_i     (arst_n_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_write_i  (reg_write_i),
      .reg_read_i   (reg_read_i),
      .reg_rdata_o  (reg_rdata_o),
      .utmi_rx_i    (utmi_rx_i),
      .fe_xcvrsel_o (fe_xcvrsel_o),
      .fe_termsel_o (fe_termsel_o),
      .trig_o       (trig_o),
      .led_arm_o    (led_arm_o),
      .led_cap_o    (led_cap_o),
      .rec_o        (rec_o),
      .rec_valid_o  (rec_valid_o),
      .credit_i     (credit_i)
   );

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
      assert (got == expected) else begin
         err_cnt++;
         $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, expected);
      end
   endtask

   task automatic reg_write(input pw_reg_addr_t addr, input pw_byte_t data);
      reg_addr_i  = addr;
      reg_wdata_i = data;
      reg_write_i = 1'b1;
      @(posedge fe_clk);
      #1;
      reg_write_i = 1'b0;
   endtask

   task automatic reg_expect(input pw_reg_addr_t addr, input pw_byte_t expected,
                             input string what);
      reg_addr_i = addr;
      reg_read_i = 1'b1;
      @(posedge fe_clk);
      #1;
      reg_read_i = 1'b0;
      check_value(reg_rdata_o, expected, what);   // data one cycle after the strobe
   endtask

   // xcvrsel and termsel per bus speed
   function automatic logic [2:0] speed_map(input int speed);
      case (speed)
         0:       return 3'b101;
         2:       return 3'b000;
         default: return 3'b011;
      endcase
   endfunction

   // pattern A5 5A C3 3C with a chosen third byte, then random payload
   task automatic send_packet(input pw_byte_t third, input int n_payload);
      pw_byte_t b;
      for (int i = 0; i < 4 + n_payload; i++) begin
         case (i)
            0:       b = 8'hA5;
            1:       b = 8'h5A;
            2:       b = third;
            3:       b = 8'h3C;
            default: b = pw_byte_t'($random(seed));
         endcase
         utmi_rx_i = '{data: b, rxvalid: 1'b1, rxactive: 1'b1, rxerror: 1'b0};
         @(posedge fe_clk);
         #1;
      end
      utmi_rx_i = '0;
      repeat (3) @(posedge fe_clk);
      #1;
   endtask

   task automatic arm_capture(input pw_byte_t ctrl, input int len);
      cap_len = len;
      ts_dis  = ctrl[2];
      rec_cnt = 0;
      reg_write(`PW_REG_LEN, pw_byte_t'(len));
      reg_write(`PW_REG_CTRL, ctrl);
   endtask

   task automatic wait_records(input int n);
      while (rec_cnt < n) @(posedge fe_clk);
      #1;
   endtask

   task automatic settle_check(input int n);
      wait_records(n);
      repeat (10) @(posedge fe_clk);   // room for stray records
      #1;
      check_value(rec_cnt, n, "record count");
      check_value(exp_q.size(), 0, "records still expected");
   endtask

   ////////////////////////////////////////
   // capture model, record checker, credits
   ////////////////////////////////////////
   always @(posedge fe_clk) begin
      if (trig_o && !trig_q) begin   // capture_start cycle
         trig_rises++;
         ts_cnt    = 0;
         cap_left  = cap_len;
         cap_taken = 0;
      end else begin
         ts_cnt++;
         if (cap_left > 0 && utmi_rx_i.rxvalid && utmi_rx_i.rxactive) begin
            if (cap_taken < keep_limit) begin
               cap_rec = '{timestamp: ts_dis ? pw_ts_t'(0) : pw_ts_t'(ts_cnt),
                           data:      utmi_rx_i.data,
                           rxerror:   utmi_rx_i.rxerror};
               exp_q.push_back(cap_rec);
            end
            cap_taken++;
            cap_left--;
         end
      end
      trig_q = trig_o;
   end

   always @(posedge fe_clk) begin
      if (arst_n_i && rec_valid_o) begin
         rec_cnt++;
         owed++;
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("unexpected record with data %0h at %0t", rec_o.data, $time);
         end else begin
            exp_rec = exp_q.pop_front();
            check_value({7'd0, rec_o}, {7'd0, exp_rec}, "record");
         end
      end
   end

   always @(posedge fe_clk) begin
      #1;
      credit_i = 1'b0;
      if (auto_credit && owed > 0) begin   // one credit per cycle
         credit_i = 1'b1;
         owed--;
      end
   end

   always @(posedge fe_clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the stimulus did not finish", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   initial begin
      int s;
      arst_n_i    = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      reg_write_i = 1'b0;
      reg_read_i  = 1'b0;
      utmi_rx_i   = '0;
      repeat (4) @(posedge fe_clk);
      #1;
      arst_n_i = 1'b1;
      @(posedge fe_clk);
      #1;
      check_value({trig_o, rec_valid_o, led_arm_o, led_cap_o}, 0, "outputs after reset");

      // register read-back and speed mapping
      reg_write(`PW_REG_PATTERN, 8'hA5);
      reg_write(`PW_REG_PATTERN + 4'd1, 8'h5A);
      reg_write(`PW_REG_PATTERN + 4'd2, 8'hC3);
      reg_write(`PW_REG_PATTERN + 4'd3, 8'h3C);
      for (s = 0; s < 4; s++) begin
         reg_write(`PW_REG_MASK + pw_reg_addr_t'(s), (s == 2) ? 8'hF0 : 8'hFF);
      end
      reg_write(`PW_REG_DELAY, 8'd5);
      reg_write(`PW_REG_DELAY + 4'd1, 8'd0);
      reg_write(`PW_REG_WIDTH, 8'd3);
      reg_write(`PW_REG_WIDTH + 4'd1, 8'd0);
      reg_expect(`PW_REG_PATTERN + 4'd2, 8'hC3, "pattern byte 2");
      reg_expect(`PW_REG_PATTERN + 4'd3, 8'h3C, "pattern byte 3");
      reg_expect(`PW_REG_MASK + 4'd2, 8'hF0, "mask byte 2");
      reg_expect(`PW_REG_DELAY, 8'd5, "delay low");
      reg_expect(`PW_REG_WIDTH, 8'd3, "width low");
      for (s = 0; s < 4; s++) begin
         reg_write(`PW_REG_SPEED, pw_byte_t'(s));
         reg_expect(`PW_REG_SPEED, pw_byte_t'(s), "speed");
         check_value({fe_xcvrsel_o, fe_termsel_o}, speed_map(s), "xcvrsel and termsel");
      end

      // mismatch, then a difference only in masked bits
      arm_capture(8'h03, 6);
      check_value(led_arm_o, 1, "arm led");
      send_packet(8'h00, 8);
      check_value(trig_rises, 0, "trigger count after a mismatch");
      reg_expect(`PW_REG_CTRL, 8'h03, "control while armed");
      send_packet(8'hC7, 16);
      settle_check(6);
      check_value(trig_rises, 1, "trigger count after a masked match");
      reg_expect(`PW_REG_CTRL, 8'h02, "control after trigger");
      reg_expect(`PW_REG_STATUS, 8'h04, "status after trigger");
      send_packet(8'hC3, 16);   // not rearmed
      check_value(trig_rises, 1, "trigger count without rearm");

      // zero delay, zero width, no timestamps
      reg_write(`PW_REG_DELAY, 8'd0);
      reg_write(`PW_REG_WIDTH, 8'd0);
      arm_capture(8'h07, 5);
      send_packet(8'hC3, 12);
      settle_check(5);
      check_value(trig_rises, 2, "trigger count after rearm");

      // credits withheld, then returned
      reg_write(`PW_REG_DELAY, 8'd2);
      reg_write(`PW_REG_WIDTH, 8'd4);
      auto_credit = 1'b0;
      arm_capture(8'h03, 10);
      send_packet(8'hC3, 16);
      wait_records(`PW_CREDITS);
      repeat (20) @(posedge fe_clk);
      #1;
      check_value(rec_cnt, `PW_CREDITS, "records during stall");
      auto_credit = 1'b1;
      settle_check(10);

      // FIFO overflow with no credit back
      auto_credit = 1'b0;
      keep_limit  = `PW_CREDITS + `PW_FIFO_DEPTH;
      arm_capture(8'h03, 16);
      send_packet(8'hC3, 24);
      check_value(rec_cnt, `PW_CREDITS, "records before credit return");
      reg_expect(`PW_REG_STATUS, 8'h06, "status after overflow");
      auto_credit = 1'b1;
      settle_check(keep_limit);
      reg_write(`PW_REG_CTRL, 8'h00);   // clears overflow and fired
      reg_expect(`PW_REG_STATUS, 8'h00, "status after clear");
      keep_limit = 255;

      $display("errors: checks %0d, assertions %0d", err_cnt,
               pw_sniffer_top_inst.props_inst.fail_cnt);
      if (err_cnt == 0 && pw_sniffer_top_inst.props_inst.fail_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
